//--- tb.f
src/fir_par_pkg.sv
src/coef_bus_if.sv
src/fir_segment.sv
src/sum_tree.sv
src/fir_reg_block.sv
src/fir_parallel.sv
verification/tb_clk_gen.sv
verification/tb_fir_parallel.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FIR testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_fir_parallel -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_fir_parallel 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "^Simulation passed$"; then
	exit 0
fi

echo "Pass line not found in the simulator output"
exit 1

//--- verification/tb_fir_parallel.sv
`timescale 1ns/1ps

module tb_fir_parallel;
	import fir_par_pkg::*;

	localparam int NUM_STEPS = 65;
	localparam int IMPULSE_STEPS = 17;
	localparam int RANDOM_END = 41;
	localparam int REG_END = 53;
	localparam int REWRITE_TAP = 5;
	localparam logic signed [SAMPLE_W-1:0] REWRITE_VAL = -16'sd12345;
	localparam int PORT_LATENCY = NUM_FIR + TREE_STAGES;
	localparam int WAIT_LIMIT = 50;
	localparam int DRIVE_DLY = 1;

	logic clk;
	logic rst_n;
	logic signed [SAMPLE_W-1:0] sample;
	logic sample_valid;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [REG_DATA_W-1:0] reg_wdata;
	logic reg_we;
	logic reg_re;
	logic signed [Y_W-1:0] y;
	logic y_valid;
	logic [REG_DATA_W-1:0] rd_data;
	logic rd_valid;

	// Mixed signs and both extremes so the sum reaches the top bits of y_o
	logic signed [SAMPLE_W-1:0] coef_tab [NUM_TAPS] = '{
		16'sd1021, -16'sd2047, 16'sd32767, 16'sh8000,
		16'sd7, -16'sd1, 16'sd15000, -16'sd9876,
		16'sd4242, 16'sd123, -16'sd30000, 16'sd2,
		16'sd31000, -16'sd555, 16'sd8191, -16'sd4096
	};

	logic signed [SAMPLE_W-1:0] step_sample [NUM_STEPS];
	logic step_src [NUM_STEPS];
	string step_name [NUM_STEPS];

	logic signed [SAMPLE_W-1:0] coef_cur [NUM_TAPS];
	logic signed [SAMPLE_W-1:0] hist [NUM_TAPS];

	tb_clk_gen u_clk_gen (
		.clk_o(clk),
		.rst_no(rst_n)
	);

	fir_parallel UUT (
		.clk_i(clk),
		.rst_ni(rst_n),
		.sample_i(sample),
		.sample_valid_i(sample_valid),
		.reg_addr_i(reg_addr),
		.reg_wdata_i(reg_wdata),
		.reg_we_i(reg_we),
		.reg_re_i(reg_re),
		.y_o(y),
		.y_valid_o(y_valid),
		.rd_data_o(rd_data),
		.rd_valid_o(rd_valid)
	);

	task automatic tick();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic check(input string name, input longint expected, input longint actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic give_up(input string what);
		$display("ERROR: %s", what);
		$display("Simulation failed");
		$fatal(1, "Stopped on a timeout");
	endtask

	// Impulse first, then random samples by port, by register, and by port again
	task automatic build_table();
		int seed;
		seed = 75;
		for (int i = 0; i < NUM_STEPS; i++) begin
			if (i < IMPULSE_STEPS) begin
				step_sample[i] = (i == 0) ? 16'sd1 : 16'sd0;
				step_src[i] = 1'b0;
				step_name[i] = $sformatf("impulse_%0d", i);
			end else begin
				step_sample[i] = SAMPLE_W'($random(seed));
				step_src[i] = (i >= RANDOM_END) && (i < REG_END);
				if (i < RANDOM_END) begin
					step_name[i] = $sformatf("random_port_%0d", i);
				end else if (i < REG_END) begin
					step_name[i] = $sformatf("reg_inject_%0d", i);
				end else begin
					step_name[i] = $sformatf("coef_rewrite_%0d", i);
				end
			end
		end
	endtask

	// y[n] is the sum of coefficient j times the sample j steps back
	task automatic model_step(input logic signed [SAMPLE_W-1:0] value, output longint expected);
		for (int j = NUM_TAPS - 1; j > 0; j--) begin
			hist[j] = hist[j-1];
		end
		hist[0] = value;
		expected = 0;
		for (int j = 0; j < NUM_TAPS; j++) begin
			expected += longint'(coef_cur[j]) * longint'(hist[j]);
		end
	endtask

	task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
		reg_addr = addr;
		reg_wdata = data;
		reg_we = 1'b1;
		tick();
		reg_we = 1'b0;
	endtask

	task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [REG_DATA_W-1:0] data);
		int waited;
		waited = 0;
		reg_addr = addr;
		reg_re = 1'b1;
		tick();
		reg_re = 1'b0;
		while (!rd_valid) begin
			if (waited >= WAIT_LIMIT) give_up("no read response came from the register bus");
			tick();
			waited++;
		end
		data = rd_data;
	endtask

	// Latency counts cycles from the strobe cycle to the cycle with y_valid_o high
	task automatic send_sample(input logic signed [SAMPLE_W-1:0] value, input logic by_reg,
		output int latency);
		if (by_reg) begin
			reg_addr = ADDR_SAMPLE;
			reg_wdata = value;
			reg_we = 1'b1;
		end else begin
			sample = value;
			sample_valid = 1'b1;
		end
		tick();
		reg_we = 1'b0;
		sample_valid = 1'b0;
		latency = 1;
		while (!y_valid) begin
			if (latency > WAIT_LIMIT) give_up("y_valid_o never rose after a sample was sent");
			tick();
			latency++;
		end
	endtask

	// Port samples go in at the minimum spacing while earlier sums are still in the tree
	task automatic stream_port(input int first, input int last, output longint y_last);
		longint expected_q [$];
		int idx_q [$];
		longint expected;
		int idx;
		bit due;
		y_last = 0;
		for (int c = 0; c <= (last - first - 1) * NUM_FIR + PORT_LATENCY; c++) begin
			due = (c >= PORT_LATENCY) && ((c - PORT_LATENCY) % NUM_FIR == 0);
			check($sformatf("random_port cycle %0d y_valid_o", c), longint'(due),
				longint'(y_valid));
			if (due) begin
				idx = idx_q.pop_front();
				y_last = longint'(y);
				check({step_name[idx], " y_o"}, expected_q.pop_front(), y_last);
			end
			if ((c % NUM_FIR == 0) && (first + c / NUM_FIR < last)) begin
				idx = first + c / NUM_FIR;
				model_step(step_sample[idx], expected);
				expected_q.push_back(expected);
				idx_q.push_back(idx);
				sample = step_sample[idx];
				sample_valid = 1'b1;
			end
			tick();
			sample_valid = 1'b0;
		end
	endtask

	initial begin
		int latency;
		int waited;
		longint expected;
		longint y_seen;
		logic [REG_DATA_W-1:0] lo;
		logic [REG_DATA_W-1:0] mid;
		logic [REG_DATA_W-1:0] hi;
		logic [REG_DATA_W-1:0] shift_word;

		sample = '0;
		sample_valid = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		reg_we = 1'b0;
		reg_re = 1'b0;
		build_table();
		hist = '{default: '0};
		coef_cur = coef_tab;

		waited = 0;
		while (!rst_n) begin
			if (waited >= WAIT_LIMIT) give_up("reset was never released");
			tick();
			waited++;
		end
		tick();

		for (int j = 0; j < NUM_TAPS; j++) begin
			reg_write(ADDR_COEF_BASE + REG_ADDR_W'(j), coef_tab[j]);
		end

		for (int i = 0; i < NUM_STEPS; i++) begin
			if (i == REG_END) begin
				reg_write(ADDR_COEF_BASE + REG_ADDR_W'(REWRITE_TAP), REWRITE_VAL);
				coef_cur[REWRITE_TAP] = REWRITE_VAL;
			end
			if ((i >= IMPULSE_STEPS) && (i < RANDOM_END)) begin
				// The random port run goes in as one burst
				if (i == IMPULSE_STEPS) begin
					stream_port(IMPULSE_STEPS, RANDOM_END, y_seen);
				end
			end else begin
				model_step(step_sample[i], expected);
				// The impulse walks the coefficients out in tap order
				if (i < IMPULSE_STEPS) begin
					expected = (i < NUM_TAPS) ? longint'(coef_tab[i]) : 0;
				end
				send_sample(step_sample[i], step_src[i], latency);
				check({step_name[i], " latency"},
					longint'(step_src[i] ? PORT_LATENCY + 1 : PORT_LATENCY), longint'(latency));
				y_seen = longint'(y);
				check({step_name[i], " y_o"}, expected, y_seen);

				// The result register loads at the end of the valid cycle
				tick();
			end

			if ((i < IMPULSE_STEPS) || (i >= RANDOM_END - 1)) begin
				reg_read(ADDR_Y_LO, lo);
				reg_read(ADDR_Y_MID, mid);
				reg_read(ADDR_Y_HI, hi);
				check({step_name[i], " readback"}, y_seen, longint'($signed({hi, mid, lo})));
				if (i >= NUM_TAPS) begin
					reg_read(ADDR_SHIFT_OUT, shift_word);
					check({step_name[i], " shift_out"}, longint'(step_sample[i-NUM_TAPS]),
						longint'($signed(shift_word)));
				end
			end
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_no
);
	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 4;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// Release lands just after an edge so no flop sees it mid-update
	initial begin
		rst_no = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		rst_no = 1'b1;
	end

endmodule

//--- src/fir_parallel.sv
`timescale 1ns/1ps

module fir_parallel (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic signed [fir_par_pkg::SAMPLE_W-1:0] sample_i,
	input  logic sample_valid_i,
	input  logic [fir_par_pkg::REG_ADDR_W-1:0] reg_addr_i,
	input  logic [fir_par_pkg::REG_DATA_W-1:0] reg_wdata_i,
	input  logic reg_we_i,
	input  logic reg_re_i,
	output logic signed [fir_par_pkg::Y_W-1:0] y_o,
	output logic y_valid_o,
	output logic [fir_par_pkg::REG_DATA_W-1:0] rd_data_o,
	output logic rd_valid_o
);
	import fir_par_pkg::*;

	logic signed [SAMPLE_W-1:0] reg_sample;
	logic reg_sample_valid;

	// Entry k feeds segment k, entry NUM_FIR is the last shift-out
	logic signed [SAMPLE_W-1:0] chain_sample [NUM_FIR+1];
	logic chain_valid [NUM_FIR+1];
	logic signed [SEG_SUM_W-1:0] seg_y [NUM_FIR];

	coef_bus_if coef_bus ();

	fir_reg_block u_regs (
		.clk_i,
		.rst_ni,
		.reg_addr_i,
		.reg_wdata_i,
		.reg_we_i,
		.reg_re_i,
		.y_i(y_o),
		.y_valid_i(y_valid_o),
		.shift_sample_i(chain_sample[NUM_FIR]),
		.shift_valid_i(chain_valid[NUM_FIR]),
		.reg_sample_o(reg_sample),
		.reg_sample_valid_o(reg_sample_valid),
		.rd_data_o,
		.rd_valid_o,
		.coef(coef_bus.reg_mp)
	);

	// A register-written sample wins over the port when both strobe together
	assign chain_sample[0] = reg_sample_valid ? reg_sample : sample_i;
	assign chain_valid[0] = reg_sample_valid || sample_valid_i;

	for (genvar k = 0; k < NUM_FIR; k++) begin : g_seg
		fir_segment #(
			.SEG_INDEX(k)
		) u_seg (
			.clk_i,
			.rst_ni,
			.sample_i(chain_sample[k]),
			.sample_valid_i(chain_valid[k]),
			.coef(coef_bus.seg_mp),
			.shift_sample_o(chain_sample[k+1]),
			.shift_valid_o(chain_valid[k+1]),
			.seg_y_o(seg_y[k])
		);
	end

	// By the last segment's strobe every seg_y comes from the same input
	sum_tree u_tree (
		.clk_i,
		.rst_ni,
		.in_valid_i(chain_valid[NUM_FIR]),
		.seg_y_i(seg_y),
		.y_o,
		.y_valid_o
	);

endmodule

//--- src/fir_reg_block.sv
`timescale 1ns/1ps

module fir_reg_block (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic [fir_par_pkg::REG_ADDR_W-1:0] reg_addr_i,
	input  logic [fir_par_pkg::REG_DATA_W-1:0] reg_wdata_i,
	input  logic reg_we_i,
	input  logic reg_re_i,
	input  logic signed [fir_par_pkg::Y_W-1:0] y_i,
	input  logic y_valid_i,
	input  logic signed [fir_par_pkg::SAMPLE_W-1:0] shift_sample_i,
	input  logic shift_valid_i,
	output logic signed [fir_par_pkg::SAMPLE_W-1:0] reg_sample_o,
	output logic reg_sample_valid_o,
	output logic [fir_par_pkg::REG_DATA_W-1:0] rd_data_o,
	output logic rd_valid_o,
	coef_bus_if.reg_mp coef
);
	import fir_par_pkg::*;

	localparam int HI_W = Y_W - 2 * REG_DATA_W;

	logic [REG_ADDR_W-1:0] coef_idx;
	logic coef_sel;
	logic signed [Y_W-1:0] y_q;
	logic signed [SAMPLE_W-1:0] shift_q;
	logic [REG_DATA_W-1:0] rd_mux;

	// Addresses below the base wrap to large indices and fall out of range
	assign coef_idx = reg_addr_i - ADDR_COEF_BASE;
	assign coef_sel = coef_idx < REG_ADDR_W'(NUM_TAPS);

	assign coef.we = reg_we_i && coef_sel;
	assign coef.seg = coef_idx[TAP_IDX_W +: SEG_IDX_W];
	assign coef.tap = coef_idx[TAP_IDX_W-1:0];
	assign coef.data = reg_wdata_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			reg_sample_o <= '0;
			reg_sample_valid_o <= 1'b0;
			y_q <= '0;
			shift_q <= '0;
		end else begin
			reg_sample_valid_o <= reg_we_i && (reg_addr_i == ADDR_SAMPLE);
			if (reg_we_i && (reg_addr_i == ADDR_SAMPLE)) begin
				reg_sample_o <= reg_wdata_i;
			end
			if (y_valid_i) begin
				y_q <= y_i;
			end
			if (shift_valid_i) begin
				shift_q <= shift_sample_i;
			end
		end
	end

	always_comb begin
		case (reg_addr_i)
			ADDR_Y_LO:      rd_mux = y_q[REG_DATA_W-1:0];
			ADDR_Y_MID:     rd_mux = y_q[2*REG_DATA_W-1:REG_DATA_W];
			ADDR_Y_HI:      rd_mux = {{(REG_DATA_W-HI_W){y_q[Y_W-1]}}, y_q[Y_W-1:2*REG_DATA_W]};
			ADDR_SHIFT_OUT: rd_mux = shift_q;
			default:        rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rd_data_o <= '0;
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= reg_re_i;
			if (reg_re_i) begin
				rd_data_o <= rd_mux;
			end
		end
	end

	a_no_rw_clash: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(reg_we_i && reg_re_i))
		else $error("Register read and write in the same cycle");

endmodule

//--- src/sum_tree.sv
`timescale 1ns/1ps

module sum_tree (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic in_valid_i,
	input  logic signed [fir_par_pkg::SEG_SUM_W-1:0] seg_y_i [fir_par_pkg::NUM_FIR],
	output logic signed [fir_par_pkg::Y_W-1:0] y_o,
	output logic y_valid_o
);
	import fir_par_pkg::*;

	logic [TREE_STAGES-1:0] vld_q;
	logic signed [Y_W-1:0] flat_sum;

	// Level l holds NUM_FIR >> (l+1) sums, one bit wider than the level below
	for (genvar l = 0; l < TREE_STAGES; l++) begin : g_lvl
		localparam int W = SEG_SUM_W + l + 1;
		localparam int N = NUM_FIR >> (l + 1);

		logic signed [W-1:0] sum_q [N];

		for (genvar n = 0; n < N; n++) begin : g_node
			logic signed [W-2:0] op_a;
			logic signed [W-2:0] op_b;

			if (l == 0) begin : g_leaf
				assign op_a = seg_y_i[2*n];
				assign op_b = seg_y_i[2*n+1];
			end else begin : g_inner
				assign op_a = g_lvl[l-1].sum_q[2*n];
				assign op_b = g_lvl[l-1].sum_q[2*n+1];
			end

			always_ff @(posedge clk_i) begin
				sum_q[n] <= W'(op_a) + W'(op_b);
			end
		end
	end

	assign y_o = g_lvl[TREE_STAGES-1].sum_q[0];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			vld_q <= '0;
		end else begin
			vld_q <= (vld_q << 1) | TREE_STAGES'(in_valid_i);
		end
	end

	assign y_valid_o = vld_q[TREE_STAGES-1];

	// Flat sum of the segment results that the tree output must reproduce
	always_comb begin
		flat_sum = '0;
		for (int k = 0; k < NUM_FIR; k++) begin
			flat_sum = flat_sum + Y_W'(seg_y_i[k]);
		end
	end

	a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
		y_valid_o |-> $past(in_valid_i, TREE_STAGES) && (y_o == $past(flat_sum, TREE_STAGES)))
		else $error("Tree output strobe without a matching input strobe or sum");

endmodule

//--- src/fir_segment.sv
`timescale 1ns/1ps

module fir_segment #(
	parameter int SEG_INDEX = 0
) (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic signed [fir_par_pkg::SAMPLE_W-1:0] sample_i,
	input  logic sample_valid_i,
	coef_bus_if.seg_mp coef,
	output logic signed [fir_par_pkg::SAMPLE_W-1:0] shift_sample_o,
	output logic shift_valid_o,
	output logic signed [fir_par_pkg::SEG_SUM_W-1:0] seg_y_o
);
	import fir_par_pkg::*;

	logic signed [SAMPLE_W-1:0] line_q [TAPS_PER_SEG];
	logic signed [SAMPLE_W-1:0] line_d [TAPS_PER_SEG];
	logic signed [SAMPLE_W-1:0] coef_q [TAPS_PER_SEG];
	logic signed [PROD_W-1:0] prod [TAPS_PER_SEG];
	logic signed [SEG_SUM_W-1:0] mac;
	logic coef_hit;

	// Slot 0 takes the newest sample, the rest move one place down
	always_comb begin
		line_d[0] = sample_i;
		for (int j = 1; j < TAPS_PER_SEG; j++) begin
			line_d[j] = line_q[j-1];
		end
	end

	// MAC over the line as it will look after the shift
	always_comb begin
		mac = '0;
		for (int j = 0; j < TAPS_PER_SEG; j++) begin
			prod[j] = line_d[j] * coef_q[j];
			mac = mac + SEG_SUM_W'(prod[j]);
		end
	end

	assign coef_hit = coef.we && (coef.seg == SEG_IDX_W'(SEG_INDEX));

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			coef_q <= '{default: '0};
		end else if (coef_hit) begin
			coef_q[coef.tap] <= coef.data;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			line_q <= '{default: '0};
			seg_y_o <= '0;
			shift_sample_o <= '0;
			shift_valid_o <= 1'b0;
		end else begin
			shift_valid_o <= sample_valid_i;
			if (sample_valid_i) begin
				line_q <= line_d;
				seg_y_o <= mac;
				// Oldest sample before the shift moves on to the next segment
				shift_sample_o <= line_q[TAPS_PER_SEG-1];
			end
		end
	end

	// The chain needs NUM_FIR cycles to settle before the next sample enters
	property p_strobe_spacing;
		@(posedge clk_i) disable iff (!rst_ni)
		sample_valid_i |=> !sample_valid_i [*(NUM_FIR-1)];
	endproperty

	a_strobe_spacing: assert property (p_strobe_spacing)
		else $error("Input strobes closer than %0d cycles in segment %0d", NUM_FIR, SEG_INDEX);

endmodule

//--- src/coef_bus_if.sv
`timescale 1ns/1ps

interface coef_bus_if;
	import fir_par_pkg::*;

	// Single-cycle write strobe
	logic we;
	// Target segment and the tap slot inside it
	logic [SEG_IDX_W-1:0] seg;
	logic [TAP_IDX_W-1:0] tap;
	logic signed [SAMPLE_W-1:0] data;

	modport reg_mp (
		output we,
		output seg,
		output tap,
		output data
	);

	modport seg_mp (
		input we,
		input seg,
		input tap,
		input data
	);

endinterface

//--- src/fir_par_pkg.sv
package fir_par_pkg;

	// Sample and coefficient width, both signed
	localparam int SAMPLE_W = 16;

	// Segment count must stay a power of two for the adder tree
	localparam int NUM_FIR = 4;
	localparam int TAPS_PER_SEG = 4;
	localparam int NUM_TAPS = NUM_FIR * TAPS_PER_SEG;

	localparam int SEG_IDX_W = $clog2(NUM_FIR);
	localparam int TAP_IDX_W = $clog2(TAPS_PER_SEG);

	localparam int PROD_W = 32;
	// Two guard bits cover the additions inside one segment
	localparam int SEG_SUM_W = PROD_W + 2;
	localparam int TREE_STAGES = $clog2(NUM_FIR);
	localparam int Y_W = SEG_SUM_W + TREE_STAGES;

	localparam int REG_ADDR_W = 6;
	localparam int REG_DATA_W = 16;

	// Register map
	localparam logic [REG_ADDR_W-1:0] ADDR_SAMPLE = 6'h00;
	localparam logic [REG_ADDR_W-1:0] ADDR_Y_LO = 6'h01;
	localparam logic [REG_ADDR_W-1:0] ADDR_Y_MID = 6'h02;
	localparam logic [REG_ADDR_W-1:0] ADDR_Y_HI = 6'h03;
	localparam logic [REG_ADDR_W-1:0] ADDR_SHIFT_OUT = 6'h04;
	// Coefficients occupy NUM_TAPS addresses from here, global tap index first
	localparam logic [REG_ADDR_W-1:0] ADDR_COEF_BASE = 6'h10;

endpackage
